// File: hw/ethFramePkg.sv
/*
 * Ethernet frame definitions for the switch receive path
 *   FPGA MAC address union (raw word or company id, kind, board fields)
 *   FPGA company id and interface kind constants, broadcast address
 *   Delimiter byte, header byte offsets, EtherType and IPv4 header size
 *   CRC-32 residue and the saturating byte count type
 */
`default_nettype none

package ethFramePkg;

  // FPGA MAC address, read as a whole or split into its fields
  typedef union packed {
    logic [47:0] raw;
    struct packed {
      logic [23:0] cid;    // Company id
      logic [15:0] kind;   // RT or PS interface
      logic [3:0]  pad;
      logic [3:0]  board;  // Board id
    } fpga;
  } macAddrU;

  localparam logic [23:0] LcsrCid          = 24'hfa610e;
  localparam logic [23:0] LcsrCidMulticast = LcsrCid | 24'h010000;  // Group bit set
  localparam logic [15:0] FpgaRtKind       = 16'h1394;
  localparam logic [15:0] FpgaPsKind       = 16'h0300;
  localparam logic [47:0] BroadcastMac     = '1;

  localparam logic [7:0] SfdByte = 8'hd5;  // Ends the preamble

  // Byte offsets inside the 14-byte header
  localparam int HdrDestOff = 0;
  localparam int HdrSrcOff  = 6;
  localparam int HdrTypeOff = 12;
  localparam int HdrLen     = 14;

  localparam logic [15:0] EtherTypeIpv4 = 16'h0800;
  localparam int          Ipv4HdrLen    = 20;  // Bytes, no options

  // Register value after a good frame including its FCS
  // Shift register kept MSB first, bytes fed LSB first
  localparam logic [31:0] CrcResidue = 32'hc704dd7b;

  // Byte index, holds at 31
  typedef logic [4:0] dataCntT;

endpackage

`default_nettype wire

// File: hw/rxForwardResult.sv
/*
 * Forwarding decision and frame result
 *   Learned table of FPGA boards behind an Ethernet in-port
 *   Broadcast, multicast, primary and FPGA address classes
 *   Per out-port forward mask, registered with the error flags
 */
`timescale 1ns/1ps
`default_nettype none

module rxForwardResult #(
  parameter int RxInIndex = switchCfgPkg::PortEth1
) (
  input  logic                  RxClk,
  input  logic                  reset,
  input  logic                  headerDone,
  input  ethFramePkg::macAddrU  destMac,
  input  ethFramePkg::macAddrU  srcMac,
  input  logic                  frameEnd,
  input  logic                  crcError,
  input  logic                  ipv4Error,
  input  switchCfgPkg::boardIdT boardId,
  input  switchCfgPkg::fwdMaskT portActive,
  output logic                  frameDone,
  output switchCfgPkg::fwdMaskT fwdMask,
  output logic                  crcErrorOut,
  output logic                  ipv4ErrorOut
);
  import ethFramePkg::*;
  import switchCfgPkg::*;

  localparam bit IsEthIn = (RxInIndex == PortEth1) || (RxInIndex == PortEth2);

  boardMaskT   learned;                // Boards seen as source on this port
  logic [47:0] primaryAddr [NumPorts];
  fwdMaskT     primaryMatch;
  fwdMaskT     fwdNext;
  logic        isBroadcast;
  logic        isMulticast;
  logic        fpgaMatch;
  logic        noMatch;

  // Only Ethernet in-ports learn, link down forgets everything
  always_ff @(posedge RxClk) begin
    if (reset || !IsEthIn || !portActive[RxInIndex])
      learned <= '0;
    else if (headerDone && srcMac.fpga.cid == LcsrCid)
      learned[srcMac.fpga.board] <= 1'b1;  // RT or PS kind alike
  end

  assign isBroadcast = destMac.raw == BroadcastMac;
  assign isMulticast = destMac.fpga.cid == LcsrCidMulticast && destMac.raw[7:0] == 8'hff;

  // Board not behind this port and not this board, so try the other side
  assign fpgaMatch = destMac.fpga.cid == LcsrCid && !learned[destMac.fpga.board] &&
                     destMac.fpga.board != boardId;

  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      if (p == PortPs)
        primaryAddr[p] = {LcsrCid, FpgaPsKind, 4'd0, boardId};
      else if (p == PortRt)
        primaryAddr[p] = {LcsrCid, FpgaRtKind, 4'd0, boardId};
      else
        primaryAddr[p] = BroadcastMac;  // No host known on the other Ethernet port
      primaryMatch[p] = (p != RxInIndex) && (destMac.raw == primaryAddr[p]);
    end
  end

  assign noMatch = !(|primaryMatch) && !fpgaMatch;  // Unknown goes out on Ethernet

  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      if (p == RxInIndex)
        fwdNext[p] = 1'b0;  // Never back out the in-port
      else if (p == PortPs || p == PortRt)
        fwdNext[p] = portActive[p] && (isBroadcast || isMulticast || primaryMatch[p]);
      else
        fwdNext[p] = portActive[p] &&
                     (isBroadcast || isMulticast || primaryMatch[p] || fpgaMatch || noMatch);
    end
  end

  always_ff @(posedge RxClk) begin
    if (reset)
      frameDone <= 1'b0;
    else
      frameDone <= frameEnd;
  end

  // Result fields, qualified by frameDone
  always_ff @(posedge RxClk) begin
    if (frameEnd) begin
      fwdMask      <= fwdNext;
      crcErrorOut  <= crcError;
      ipv4ErrorOut <= ipv4Error;
    end
  end

  // Frame ends are at least two cycles apart
  frameDoneSingle: assert property (@(posedge RxClk) disable iff (reset)
    frameDone |=> !frameDone);

endmodule

`default_nettype wire

// File: hw/rxFrameCheck.sv
/*
 * Receive frame checks
 *   Bytewise CRC-32 over header, payload and FCS, residue compare
 *   IPv4 header checksum over the first 20 payload bytes
 *   Error flags, final in the cycle of the frame end pulse
 */
`timescale 1ns/1ps
`default_nettype none

module rxFrameCheck (
  input  logic                 RxClk,
  input  logic                 reset,
  input  logic                 frameStart,
  input  logic                 byteValid,
  input  logic [7:0]           byteData,
  input  logic                 inPayload,
  input  ethFramePkg::dataCntT dataCnt,
  input  logic [15:0]          etherType,
  output logic                 crcError,
  output logic                 ipv4Error
);
  import ethFramePkg::*;

  localparam logic [31:0] CrcPoly = 32'h04c11db7;  // IEEE 802.3

  logic [31:0] crcReg;
  logic [31:0] crcNext;
  logic [7:0]  crcByte;   // Byte in wire bit order
  logic [16:0] ipSum;     // 16-bit sum plus pending carry
  logic        ipByte;    // Byte inside the IPv4 header
  logic        ipCheckAt; // First byte after the IPv4 header

  // Shift in one byte, MSB of the data word first
  function automatic logic [31:0] crcFold(input logic [31:0] crcIn, input logic [7:0] data);
    logic [31:0] crc;
    logic        fb;
    crc = crcIn;
    for (int i = 7; i >= 0; i--) begin
      fb  = crc[31] ^ data[i];
      crc = {crc[30:0], 1'b0};
      if (fb)
        crc = crc ^ CrcPoly;
    end
    return crc;
  endfunction

  // Ethernet sends LSB first
  always_comb begin
    for (int i = 0; i < 8; i++)
      crcByte[i] = byteData[7-i];
  end

  assign crcNext = crcFold(crcReg, crcByte);

  always_ff @(posedge RxClk) begin
    if (reset || frameStart)
      crcReg <= '1;  // Seed
    else if (byteValid)
      crcReg <= crcNext;
  end

  assign crcError = crcReg != CrcResidue;

  assign ipByte    = byteValid && inPayload && dataCnt < dataCntT'(Ipv4HdrLen);
  assign ipCheckAt = byteValid && inPayload && dataCnt == dataCntT'(Ipv4HdrLen);

  // Even bytes are the high half of a word, carry folds back in with them
  always_ff @(posedge RxClk) begin
    if (ipByte) begin
      if (dataCnt == '0)
        ipSum <= {1'b0, byteData, 8'd0};
      else if (!dataCnt[0])
        ipSum <= {1'b0, ipSum[15:0]} + {1'b0, byteData, 7'd0, ipSum[16]};
      else
        ipSum <= ipSum + {9'd0, byteData};
    end
  end

  always_ff @(posedge RxClk) begin
    if (reset || frameStart)
      ipv4Error <= 1'b0;
    else if (ipCheckAt)
      // All ones, or all ones with the last carry still pending
      ipv4Error <= (etherType == EtherTypeIpv4) &&
                   !(ipSum == 17'h0ffff || ipSum == 17'h1fffe);
  end

endmodule

`default_nettype wire

// File: hw/rxFrameDecode.sv
/*
 * Receive frame decoder
 *   Idle, header and payload FSM started by the delimiter byte
 *   Header capture with destination, source and EtherType fields
 *   Registered byte stream, payload byte count and frame pulses
 */
`timescale 1ns/1ps
`default_nettype none

module rxFrameDecode (
  input  logic                 RxClk,
  input  logic                 reset,
  input  logic                 rxValid,
  input  logic [7:0]           rxData,
  output logic                 frameStart,  // Delimiter seen
  output logic                 byteValid,   // Header or payload byte on byteData
  output logic [7:0]           byteData,
  output logic                 inPayload,
  output ethFramePkg::dataCntT dataCnt,     // Payload byte index
  output logic [15:0]          etherType,
  output logic                 headerDone,  // With last header byte
  output ethFramePkg::macAddrU destMac,
  output ethFramePkg::macAddrU srcMac,
  output logic                 frameEnd
);
  import ethFramePkg::*;

  localparam logic [1:0] StIdle    = 2'd0;
  localparam logic [1:0] StHeader  = 2'd1;
  localparam logic [1:0] StPayload = 2'd2;

  logic [1:0] rxState;
  dataCntT    byteCnt;       // Header index and then payload index
  logic [7:0] hdr [HdrLen];  // Captured header bytes

  always_ff @(posedge RxClk) begin
    if (reset) begin
      rxState    <= StIdle;
      byteCnt    <= '0;
      dataCnt    <= '0;
      frameStart <= 1'b0;
      byteValid  <= 1'b0;
      inPayload  <= 1'b0;
      headerDone <= 1'b0;
      frameEnd   <= 1'b0;
    end else begin
      frameStart <= 1'b0;  // All pulses one cycle
      headerDone <= 1'b0;
      frameEnd   <= 1'b0;
      byteValid  <= 1'b0;
      inPayload  <= 1'b0;
      case (rxState)
        StIdle: begin
          // Preamble bytes are not checked
          if (rxValid && rxData == SfdByte) begin
            rxState    <= StHeader;
            byteCnt    <= '0;
            frameStart <= 1'b1;
          end
        end
        StHeader: begin
          if (rxValid) begin
            byteValid <= 1'b1;
            if (byteCnt == dataCntT'(HdrLen - 1)) begin
              headerDone <= 1'b1;
              byteCnt    <= '0;
              rxState    <= StPayload;
            end else begin
              byteCnt <= byteCnt + 1'b1;
            end
          end else begin
            rxState <= StIdle;  // Runt is dropped without a result
          end
        end
        StPayload: begin
          if (rxValid) begin
            byteValid <= 1'b1;
            inPayload <= 1'b1;
            dataCnt   <= byteCnt;
            if (byteCnt != '1)
              byteCnt <= byteCnt + 1'b1;  // Holds at 31
          end else begin
            frameEnd <= 1'b1;
            rxState  <= StIdle;
          end
        end
        default: rxState <= StIdle;
      endcase
    end
  end

  // Byte pipe and header store
  always_ff @(posedge RxClk) begin
    byteData <= rxData;
    if (rxState == StHeader && rxValid)
      hdr[byteCnt[3:0]] <= rxData;
  end

  assign etherType = {hdr[HdrTypeOff], hdr[HdrTypeOff+1]};  // Big endian on the wire

  // First byte on the wire is the MSB of the address
  always_comb begin
    for (int i = 0; i < 6; i++) begin
      destMac.raw[47-8*i -: 8] = hdr[HdrDestOff+i];
      srcMac.raw[47-8*i -: 8]  = hdr[HdrSrcOff+i];
    end
  end

  // Header end comes exactly HdrLen unbroken bytes after the delimiter
  headerDoneInHeader: assert property (@(posedge RxClk) disable iff (reset)
    headerDone |-> $past(frameStart, HdrLen));

endmodule

`default_nettype wire

// File: hw/rxPortTop.sv
/*
 * Receive path of one switch in-port
 *   Frame decoder, CRC and IPv4 checks, forwarding result
 */
`timescale 1ns/1ps
`default_nettype none

module rxPortTop #(
  parameter int RxInIndex = switchCfgPkg::PortEth1
) (
  input  logic                  RxClk,
  input  logic                  reset,
  input  logic                  rxValid,
  input  logic [7:0]            rxData,
  input  switchCfgPkg::boardIdT boardId,
  input  switchCfgPkg::fwdMaskT portActive,
  output logic                  frameDone,
  output switchCfgPkg::fwdMaskT fwdMask,
  output logic                  crcError,
  output logic                  ipv4Error
);
  import ethFramePkg::*;

  logic        frameStart;
  logic        byteValid;
  logic [7:0]  byteData;
  logic        inPayload;
  dataCntT     dataCnt;
  logic [15:0] etherType;
  logic        headerDone;
  macAddrU     destMac;
  macAddrU     srcMac;
  logic        frameEnd;
  logic        chkCrcError;   // Running flags from the checker
  logic        chkIpv4Error;

  rxFrameDecode i_rxFrameDecode (
    .RxClk(RxClk), .reset(reset), .rxValid(rxValid), .rxData(rxData),
    .frameStart(frameStart), .byteValid(byteValid), .byteData(byteData),
    .inPayload(inPayload), .dataCnt(dataCnt), .etherType(etherType),
    .headerDone(headerDone), .destMac(destMac), .srcMac(srcMac), .frameEnd(frameEnd)
  );

  rxFrameCheck i_rxFrameCheck (
    .RxClk(RxClk), .reset(reset), .frameStart(frameStart), .byteValid(byteValid),
    .byteData(byteData), .inPayload(inPayload), .dataCnt(dataCnt),
    .etherType(etherType), .crcError(chkCrcError), .ipv4Error(chkIpv4Error)
  );

  rxForwardResult #(.RxInIndex(RxInIndex)) i_rxForwardResult (
    .RxClk(RxClk), .reset(reset), .headerDone(headerDone), .destMac(destMac),
    .srcMac(srcMac), .frameEnd(frameEnd), .crcError(chkCrcError),
    .ipv4Error(chkIpv4Error), .boardId(boardId), .portActive(portActive),
    .frameDone(frameDone), .fwdMask(fwdMask), .crcErrorOut(crcError),
    .ipv4ErrorOut(ipv4Error)
  );

endmodule

`default_nettype wire

// File: hw/switchCfgPkg.sv
/*
 * Switch configuration definitions
 *   Port count and port indices of the four-port switch
 *   Forward mask, board id and per-board mask types
 */
`default_nettype none

package switchCfgPkg;

  localparam int NumPorts = 4;

  // Port order, shared by all in-ports and out-ports
  localparam int PortEth1 = 0;
  localparam int PortEth2 = 1;
  localparam int PortPs   = 2;
  localparam int PortRt   = 3;

  // One bit per out-port
  typedef logic [NumPorts-1:0] fwdMaskT;

  // Board id from the rotary switch, low nibble of an FPGA MAC
  typedef logic [3:0] boardIdT;

  // One bit per board id
  typedef logic [15:0] boardMaskT;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds the rxPortTop testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module rxPortTb -Mdir obj_dir

./obj_dir/VrxPortTb > sim.log 2>&1
cat sim.log

if grep -q "tests failed" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation clean"

// File: include/frameGen.svh
/*
 * Testbench helpers, included in the testbench module
 *   LFSR bit source, random values and random MAC addresses
 *   Reflected CRC-32 reference, frame and IPv4 header building
 *   Forwarding model with its learned board table
 */
`ifndef FRAMEGEN_SVH
`define FRAMEGEN_SVH

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic lfsrBit();
  logic fb;
  fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
  lfsrState = {lfsrState[30:0], fb};
  return fb;
endfunction

function automatic logic [31:0] randBits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++)
    r = {r[30:0], lfsrBit()};  // One step per bit
  return r;
endfunction

function automatic int randRange(input int lo, input int hi);
  logic [31:0] r;
  r = randBits(16);
  return lo + int'(r % 32'(hi - lo + 1));  // lo to hi inclusive
endfunction

function automatic logic [47:0] randMac();
  logic [31:0] hi;
  logic [31:0] lo;
  logic [47:0] m;
  hi = randBits(32);
  lo = randBits(16);
  m = {hi, lo[15:0]};
  m[40] = 1'b0;  // Group bit clear, unicast
  return m;
endfunction

// Reflected CRC over the first n bytes of frameQ, no final inversion
function automatic logic [31:0] crcRef(input int n);
  logic [31:0] crc;
  crc = '1;
  for (int i = 0; i < n; i++) begin
    crc = crc ^ {24'd0, frameQ[i]};
    for (int b = 0; b < 8; b++)
      crc = crc[0] ? ((crc >> 1) ^ 32'hedb88320) : (crc >> 1);
  end
  return crc;
endfunction

function automatic void buildFrame(input logic [47:0] dest, input logic [47:0] src,
                                   input logic [15:0] typ, input int payLen);
  logic [31:0] r;
  frameQ.delete();
  for (int i = 5; i >= 0; i--)
    frameQ.push_back(dest[8*i +: 8]);  // MSB byte first on the wire
  for (int i = 5; i >= 0; i--)
    frameQ.push_back(src[8*i +: 8]);
  frameQ.push_back(typ[15:8]);
  frameQ.push_back(typ[7:0]);
  for (int i = 0; i < payLen; i++) begin
    r = randBits(8);
    frameQ.push_back(r[7:0]);
  end
endfunction

// Ones' complement sum of the ten header words
function automatic logic [15:0] ipv4Sum();
  logic [31:0] s;
  s = '0;
  for (int w = 0; w < Ipv4HdrLen / 2; w++)
    s = s + {16'd0, frameQ[HdrLen + 2*w], frameQ[HdrLen + 2*w + 1]};
  s = {16'd0, s[15:0]} + {16'd0, s[31:16]};
  s = {16'd0, s[15:0]} + {16'd0, s[31:16]};  // Second fold catches the last carry
  return s[15:0];
endfunction

function automatic void setIpv4Checksum(input bit good);
  logic [15:0] cks;
  logic [31:0] r;
  frameQ[HdrLen + 10] = 8'h00;
  frameQ[HdrLen + 11] = 8'h00;
  cks = ~ipv4Sum();
  r = randBits(8);
  if (!good)
    cks[7:0] = cks[7:0] ^ (r[7:0] | 8'h01);  // Never a zero change
  frameQ[HdrLen + 10] = cks[15:8];
  frameQ[HdrLen + 11] = cks[7:0];
endfunction

function automatic void appendFcs();
  logic [31:0] fcs;
  fcs = ~crcRef(frameQ.size());
  for (int i = 0; i < 4; i++)
    frameQ.push_back(fcs[8*i +: 8]);  // Low byte first
endfunction

function automatic logic crcErrExpect();
  return crcRef(frameQ.size()) != 32'hdebb20e3;  // Good frame residue
endfunction

function automatic logic ipv4ErrExpect();
  if ({frameQ[HdrTypeOff], frameQ[HdrTypeOff + 1]} != EtherTypeIpv4)
    return 1'b0;
  return ipv4Sum() != 16'hffff;
endfunction

// Table follows the in-port link, learns FPGA sources after a full header
function automatic void learnModel(input fwdMaskT act, input bit hdrComplete);
  logic [23:0] cid;
  logic [7:0]  last;
  cid  = {frameQ[HdrSrcOff], frameQ[HdrSrcOff + 1], frameQ[HdrSrcOff + 2]};
  last = frameQ[HdrSrcOff + 5];
  if (!act[PortEth1])
    learnedModel = '0;
  else if (hdrComplete && cid == LcsrCid)
    learnedModel[last[3:0]] = 1'b1;
endfunction

function automatic fwdMaskT maskModel(input logic [47:0] dest, input boardIdT board,
                                      input fwdMaskT act);
  logic    bcast;
  logic    mcast;
  logic    psHit;
  logic    rtHit;
  logic    fpga;
  logic    noHit;
  fwdMaskT m;
  bcast = dest == BroadcastMac;
  mcast = dest[47:24] == LcsrCidMulticast && dest[7:0] == 8'hff;
  psHit = dest == {LcsrCid, FpgaPsKind, 4'h0, board};
  rtHit = dest == {LcsrCid, FpgaRtKind, 4'h0, board};
  fpga  = dest[47:24] == LcsrCid && !learnedModel[dest[3:0]] && dest[3:0] != board;
  noHit = !(bcast || psHit || rtHit) && !fpga;  // Eth2 primary taken as broadcast
  m = '0;  // In-port Eth1 stays clear
  m[PortEth2] = act[PortEth2] && (bcast || mcast || fpga || noHit);
  m[PortPs]   = act[PortPs] && (bcast || mcast || psHit);
  m[PortRt]   = act[PortRt] && (bcast || mcast || rtHit);
  return m;
endfunction

`endif

// File: verif/rxPortTb.sv
/*
 * Testbench for the receive path of one switch in-port
 *   Clock, reset, random frames driven on the falling edge
 *   Compare tasks, per-test report lines and closing counts
 */
`timescale 1ns/1ps
`default_nettype none

module rxPortTb;
  import ethFramePkg::*;
  import switchCfgPkg::*;

  localparam int DoneTimeout = 200;  // Cycles to wait for frameDone

  logic        RxClk;
  logic        reset;
  logic        rxValid;
  logic [7:0]  rxData;
  boardIdT     boardId;
  fwdMaskT     portActive;
  logic        frameDone;
  fwdMaskT     fwdMask;
  logic        crcError;
  logic        ipv4Error;

  logic [31:0] lfsrState;
  logic [7:0]  frameQ [$];    // Header, payload and FCS
  boardMaskT   learnedModel;
  int          errCount;
  int          errAtStart;
  int          testCount;
  int          testFails;

  `include "frameGen.svh"

  rxPortTop #(.RxInIndex(PortEth1)) i_rxPortTop (
    .RxClk(RxClk), .reset(reset), .rxValid(rxValid), .rxData(rxData), .boardId(boardId),
    .portActive(portActive), .frameDone(frameDone), .fwdMask(fwdMask),
    .crcError(crcError), .ipv4Error(ipv4Error)
  );

  always #2 RxClk = !RxClk;  // 4 ns period

  task automatic compareMask(input string name, input fwdMaskT got, input fwdMaskT exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      errCount++;
    end
  endtask

  task automatic compareFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      errCount++;
    end
  endtask

  task automatic driveByte(input logic [7:0] b);
    @(negedge RxClk);
    rxValid = 1'b1;
    rxData  = b;
  endtask

  // Preamble and delimiter, then the first n bytes of frameQ
  task automatic sendBytes(input int n);
    for (int i = 0; i < 7; i++)
      driveByte(8'h55);
    driveByte(SfdByte);
    for (int i = 0; i < n; i++)
      driveByte(frameQ[i]);
    @(negedge RxClk);
    rxValid = 1'b0;  // Frame ends here
    rxData  = 8'h00;
  endtask

  task automatic waitDone(output bit seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < DoneTimeout) begin
      @(negedge RxClk);  // Outputs settled since the rising edge
      cycles++;
      seen = frameDone;
    end
  endtask

  task automatic runFrame(input logic [47:0] dest, input logic [47:0] src,
                          input logic [15:0] typ, input bit ipGood, input bit flip,
                          input fwdMaskT act);
    fwdMaskT     expMask;
    logic        expCrc;
    logic        expIp;
    bit          seen;
    int          pos;
    logic [31:0] r;
    buildFrame(dest, src, typ, randRange(46, 80));
    if (typ == EtherTypeIpv4)
      setIpv4Checksum(ipGood);
    appendFcs();
    if (flip) begin
      pos = randRange(HdrLen, frameQ.size() - 1);  // Payload or FCS
      r   = randBits(3);
      frameQ[pos] = frameQ[pos] ^ (8'h01 << r[2:0]);
    end
    learnModel(act, 1'b1);
    expMask = maskModel(dest, boardId, act);
    expCrc  = crcErrExpect();
    expIp   = ipv4ErrExpect();
    @(negedge RxClk);
    portActive = act;
    sendBytes(frameQ.size());
    waitDone(seen);
    if (!seen) begin
      $display("Timeout, no frameDone within %0d cycles after a full frame", DoneTimeout);
      errCount++;
    end else begin
      compareMask("fwdMask", fwdMask, expMask);
      compareFlag("fwdMask[in-port]", fwdMask[PortEth1], 1'b0);
      compareFlag("crcError", crcError, expCrc);
      compareFlag("ipv4Error", ipv4Error, expIp);
    end
    repeat (randRange(3, 8)) @(negedge RxClk);  // Gap
  endtask

  // Runt cut inside the header must stay silent
  task automatic cutFrame(input fwdMaskT act);
    bit seen;
    buildFrame(randMac(), randMac(), 16'h88b5, 0);
    learnModel(act, 1'b0);
    @(negedge RxClk);
    portActive = act;
    sendBytes(randRange(1, HdrLen - 1));
    waitDone(seen);
    if (seen) begin
      $display("Unexpected frameDone after a frame cut inside the header");
      errCount++;
    end
  endtask

  task automatic finishTest(input string name);
    testCount++;
    if (errCount != errAtStart) begin
      testFails++;
      $display("test %0d %s: %0d errors", testCount, name, errCount - errAtStart);
    end else begin
      $display("test %0d %s: ok", testCount, name);
    end
    errAtStart = errCount;
  endtask

  initial begin
    logic [31:0] r;
    logic [47:0] dest;
    logic [47:0] fpgaDest;
    boardIdT     b;
    RxClk        = 1'b0;
    reset        = 1'b1;
    rxValid      = 1'b0;
    rxData       = 8'h00;
    portActive   = '1;
    lfsrState    = 32'h2c23;
    learnedModel = '0;
    errCount     = 0;
    errAtStart   = 0;
    testCount    = 0;
    testFails    = 0;
    r = randBits(4);
    boardId = r[3:0];  // Fixed for the run
    repeat (5) @(negedge RxClk);
    reset = 1'b0;

    for (int i = 0; i < 8; i++) begin
      r = randBits(4);
      runFrame(randMac(), randMac(), 16'h88b5, 1'b1, 1'b0, r[3:0]);
    end
    finishTest("good unicast frames");

    for (int i = 0; i < 8; i++) begin
      r = randBits(4);
      runFrame(randMac(), randMac(), 16'h88b5, 1'b1, 1'b1, r[3:0]);
    end
    finishTest("single bit errors");

    for (int i = 0; i < 8; i++)
      runFrame(randMac(), randMac(), (i % 4 == 3) ? 16'h86dd : EtherTypeIpv4,
               i[0], 1'b0, 4'hf);  // Odd i carries a good checksum
    finishTest("ipv4 header checksum");

    for (int i = 0; i < 16; i++) begin
      r = randBits(16);
      case (i % 4)
        0:       dest = BroadcastMac;
        1:       dest = {LcsrCidMulticast, r[15:0], 8'hff};
        2:       dest = {LcsrCid, FpgaPsKind, 4'h0, boardId};
        default: dest = {LcsrCid, FpgaRtKind, 4'h0, boardId};
      endcase
      r = randBits(4);
      runFrame(dest, randMac(), 16'h88b5, 1'b1, 1'b0, r[3:0]);
    end
    finishTest("address classes");

    r = randBits(3);
    b = boardId + 4'd1 + {1'b0, r[2:0]};  // Any board but this one
    fpgaDest = {LcsrCid, FpgaRtKind, 4'h0, b};
    runFrame(fpgaDest, randMac(), 16'h88b5, 1'b1, 1'b0, 4'hf);
    runFrame(randMac(), {LcsrCid, FpgaPsKind, 4'h0, b}, 16'h88b5, 1'b1, 1'b0, 4'hf);
    runFrame(fpgaDest, randMac(), 16'h88b5, 1'b1, 1'b0, 4'hf);
    runFrame(fpgaDest, randMac(), 16'h88b5, 1'b1, 1'b0, 4'he);  // In-port down
    runFrame(fpgaDest, randMac(), 16'h88b5, 1'b1, 1'b0, 4'hf);
    finishTest("learned boards");

    for (int i = 0; i < 3; i++) begin
      cutFrame(4'hf);
      runFrame(randMac(), randMac(), EtherTypeIpv4, 1'b1, 1'b0, 4'hf);
    end
    finishTest("runt frames");

    $display("%0d tests, %0d with errors, %0d check errors", testCount, testFails, errCount);
    if (errCount == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
hw/ethFramePkg.sv
hw/switchCfgPkg.sv
hw/rxFrameDecode.sv
hw/rxFrameCheck.sv
hw/rxForwardResult.sv
hw/rxPortTop.sv
verif/rxPortTb.sv
